// ==== build.f ====
logic/mapper_pkg.sv
logic/cart_reg_file.sv
logic/a12_rise_fsm.sv
logic/scanline_irq_counter.sv
logic/bank_mapper.sv
logic/cart_mapper_top.sv
test/mapper_monitor.sv
test/tb_cart_mapper.sv

// ==== logic/a12_rise_fsm.sv ====
`timescale 1ns/1ps
module a12_rise_fsm
	import mapper_pkg::*;
#(
	parameter int A12_LOW_CYCLES = 3    // Lows needed before a rise counts
)
(
	input  logic m2,
	input  logic ppu_addr_in,           // Async reset
	input  logic a12,                   // PPU A12, sampled each edge
	output logic a12_tick               // One cycle per qualified rise
);
	localparam int CNT_W = $clog2(A12_LOW_CYCLES + 1);
	localparam logic [1:0] A12_HIGH         = 2'd0;
	localparam logic [1:0] A12_LOW_COUNTING = 2'd1;
	localparam logic [1:0] A12_ARMED        = 2'd2;

	logic [1:0]       state;
	logic [CNT_W-1:0] low_cnt;          // Consecutive low samples

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			state    <= A12_HIGH;
			low_cnt  <= '0;
			a12_tick <= 1'b0;
		end
		else
		begin
			a12_tick <= 1'b0;
			if (a12)
			begin
				a12_tick <= (state == A12_ARMED); // Rise after a long low
				state    <= A12_HIGH;             // Short dips fall back here
				low_cnt  <= '0;
			end
			else
			begin
				case (state)
					A12_HIGH:
					begin
						low_cnt <= CNT_W'(1);
						state   <= (A12_LOW_CYCLES <= 1) ? A12_ARMED : A12_LOW_COUNTING;
					end
					A12_LOW_COUNTING:
					begin
						low_cnt <= low_cnt + 1'b1;
						if (low_cnt >= CNT_W'(A12_LOW_CYCLES - 1))
							state <= A12_ARMED;   // Enough lows seen
					end
					default: ;                      // Stay armed while low
				endcase
			end
		end
	end

endmodule

// ==== logic/bank_mapper.sv ====
`timescale 1ns/1ps
module bank_mapper
	import mapper_pkg::*;
(
	input  logic                 romsel,
	input  logic                 cpu_rw,
	input  logic [14:0]          cpu_addr,
	input  logic                 ppu_rd,
	input  logic                 ppu_wr,
	input  logic [13:0]          ppu_addr,
	input  mapper_t              mapper,
	input  logic [12:0]          prg_base,
	input  logic [4:0]           prg_mask,
	input  logic [4:0]           chr_mask,
	input  logic [1:0]           sram_page,
	input  logic                 sram_en,
	input  logic                 prg_we_en,
	input  logic                 chr_we_en,
	input  mirror_t              mirroring,
	input  bank_reg_t            bank_r0,
	input  bank_reg_t            bank_r1,
	input  bank_reg_t            bank_r2,
	input  bank_reg_t            bank_r3,
	input  bank_reg_t            bank_r4,
	input  bank_reg_t            bank_r5,
	input  bank_reg_t            bank_r6,
	input  bank_reg_t            bank_r7,
	input  logic                 mmc3_prg_mode,
	input  logic                 mmc3_chr_invert,
	output logic [PRG_OUT_W-1:0] prg_addr,   // A26..A13
	output logic [CHR_OUT_W-1:0] chr_addr,   // A17..A10
	output logic                 flash_we,   // Strobes active low
	output logic                 flash_oe,
	output logic                 sram_ce,
	output logic                 sram_we,
	output logic                 sram_oe,
	output logic                 chr_oe,
	output logic                 chr_we,
	output logic                 ciram_a10
);
	logic [5:0] prg_inner;              // A18..A13 before base and mask
	logic [7:0] chr_inner;              // A17..A10 before mask

	always_comb
	begin
		case (mapper)
			MAPPER_UXROM, MAPPER_CNROM: // Last 16K fixed at $C000
				prg_inner = {cpu_addr[14] ? 5'h1f : bank_r1[4:0], cpu_addr[13]};
			MAPPER_MMC3:
			begin
				case (cpu_addr[14:13])
					2'b00: prg_inner = mmc3_prg_mode ? 6'h3e : bank_r6[5:0];
					2'b01: prg_inner = bank_r7[5:0];
					2'b10: prg_inner = mmc3_prg_mode ? bank_r6[5:0] : 6'h3e;
					default: prg_inner = 6'h3f; // $E000 always last bank
				endcase
			end
			default: prg_inner = {bank_r1[3:0], cpu_addr[14:13]}; // 32K, AxROM and NROM
		endcase
	end

	always_comb
	begin
		if (mapper == MAPPER_MMC3)
		begin
			if (ppu_addr[12] == mmc3_chr_invert)    // 2K half
				chr_inner = {ppu_addr[11] ? bank_r1[7:1] : bank_r0[7:1], ppu_addr[10]};
			else
			begin
				case (ppu_addr[11:10])              // 1K half
					2'b00: chr_inner = bank_r2;
					2'b01: chr_inner = bank_r3;
					2'b10: chr_inner = bank_r4;
					default: chr_inner = bank_r5;
				endcase
			end
		end
		else
			chr_inner = {bank_r0[4:0], ppu_addr[12:10]}; // Plain 8K bank
	end

	// SRAM page takes the PRG lines outside $8000-$FFFF
	assign prg_addr = romsel ? {{(PRG_OUT_W - 2){1'b0}}, sram_page}
		: {prg_base[12:5], prg_base[4:0] | (prg_inner[5:1] & ~prg_mask), prg_inner[0]};
	assign chr_addr = {chr_inner[7:3] & ~chr_mask, chr_inner[2:0]};

	assign flash_we = cpu_rw | romsel | ~prg_we_en;
	assign flash_oe = ~cpu_rw | romsel;
	assign sram_ce  = ~(cpu_addr[14] & cpu_addr[13] & romsel & sram_en); // $6000-$7FFF
	assign sram_we  = cpu_rw;
	assign sram_oe  = ~cpu_rw;
	assign chr_oe   = ppu_rd | ppu_addr[13];              // Nametables go to CIRAM
	assign chr_we   = ppu_wr | ppu_addr[13] | ~chr_we_en;

	always_comb
	begin
		case (mirroring)
			MIRROR_VERT:  ciram_a10 = ppu_addr[10];
			MIRROR_HORIZ: ciram_a10 = ppu_addr[11];
			MIRROR_ONE_A: ciram_a10 = 1'b0;
			default:      ciram_a10 = 1'b1;
		endcase
	end

endmodule

// ==== logic/cart_mapper_top.sv ====
`timescale 1ns/1ps
module cart_mapper_top
	import mapper_pkg::*;
#(
	parameter int A12_LOW_CYCLES = 3    // IRQ filter length in m2 edges
)
(
	input  logic                 m2,
	input  logic                 ppu_addr_in,  // Async reset, active high
	input  logic                 romsel,
	input  logic                 cpu_rw,
	input  logic [14:0]          cpu_addr,
	input  logic [7:0]           cpu_data,
	input  logic                 ppu_rd,
	input  logic                 ppu_wr,
	input  logic [13:0]          ppu_addr,
	output logic [PRG_OUT_W-1:0] prg_addr,
	output logic [CHR_OUT_W-1:0] chr_addr,
	output logic                 flash_we,
	output logic                 flash_oe,
	output logic                 sram_ce,
	output logic                 sram_we,
	output logic                 sram_oe,
	output logic                 chr_oe,
	output logic                 chr_we,
	output logic                 ciram_a10,
	output logic                 irq
);
	mapper_t     mapper;
	logic [12:0] prg_base;
	logic [4:0]  prg_mask;
	logic [4:0]  chr_mask;
	logic [1:0]  sram_page;
	logic        sram_en;
	logic        prg_we_en;
	logic        chr_we_en;
	mirror_t     mirroring;
	bank_reg_t   bank_r0, bank_r1, bank_r2, bank_r3;
	bank_reg_t   bank_r4, bank_r5, bank_r6, bank_r7;
	logic        mmc3_prg_mode;
	logic        mmc3_chr_invert;
	logic [7:0]  irq_latch;
	logic        reload_req;
	logic        irq_enable_set;
	logic        irq_disable;
	logic        a12_tick;

	cart_reg_file cart_reg_file_inst (
		.m2, .ppu_addr_in, .romsel, .cpu_rw, .cpu_addr, .cpu_data,
		.mapper, .prg_base, .prg_mask, .chr_mask, .sram_page,
		.sram_en, .prg_we_en, .chr_we_en, .mirroring,
		.bank_r0, .bank_r1, .bank_r2, .bank_r3,
		.bank_r4, .bank_r5, .bank_r6, .bank_r7,
		.mmc3_prg_mode, .mmc3_chr_invert,
		.irq_latch, .reload_req, .irq_enable_set, .irq_disable
	);

	a12_rise_fsm #(.A12_LOW_CYCLES(A12_LOW_CYCLES)) a12_rise_fsm_inst (
		.m2, .ppu_addr_in,
		.a12      (ppu_addr[12]),  // Pattern table select line
		.a12_tick
	);

	scanline_irq_counter scanline_irq_counter_inst (
		.m2, .ppu_addr_in, .a12_tick, .irq_latch,
		.reload_req, .irq_enable_set, .irq_disable, .irq
	);

	bank_mapper bank_mapper_inst (
		.romsel, .cpu_rw, .cpu_addr, .ppu_rd, .ppu_wr, .ppu_addr,
		.mapper, .prg_base, .prg_mask, .chr_mask, .sram_page,
		.sram_en, .prg_we_en, .chr_we_en, .mirroring,
		.bank_r0, .bank_r1, .bank_r2, .bank_r3,
		.bank_r4, .bank_r5, .bank_r6, .bank_r7,
		.mmc3_prg_mode, .mmc3_chr_invert,
		.prg_addr, .chr_addr, .flash_we, .flash_oe,
		.sram_ce, .sram_we, .sram_oe, .chr_oe, .chr_we, .ciram_a10
	);

endmodule

// ==== logic/cart_reg_file.sv ====
`timescale 1ns/1ps
module cart_reg_file
	import mapper_pkg::*;
(
	input  logic        m2,
	input  logic        ppu_addr_in,    // Async reset
	input  logic        romsel,         // Low for $8000-$FFFF
	input  logic        cpu_rw,
	input  logic [14:0] cpu_addr,
	input  logic [7:0]  cpu_data,
	output mapper_t     mapper,
	output logic [12:0] prg_base,       // A26..A14
	output logic [4:0]  prg_mask,       // Masks A18..A14
	output logic [4:0]  chr_mask,       // Masks A17..A13
	output logic [1:0]  sram_page,
	output logic        sram_en,
	output logic        prg_we_en,
	output logic        chr_we_en,
	output mirror_t     mirroring,
	output bank_reg_t   bank_r0,
	output bank_reg_t   bank_r1,
	output bank_reg_t   bank_r2,
	output bank_reg_t   bank_r3,
	output bank_reg_t   bank_r4,
	output bank_reg_t   bank_r5,
	output bank_reg_t   bank_r6,
	output bank_reg_t   bank_r7,
	output logic        mmc3_prg_mode,
	output logic        mmc3_chr_invert,
	output logic [7:0]  irq_latch,
	output logic        reload_req,     // One-cycle pulses
	output logic        irq_enable_set,
	output logic        irq_disable
);
	cpu_byte_u  data_u;                 // Write byte, two decodings
	bank_reg_t  regs [0:7];
	logic [2:0] bank_sel;               // MMC3 register index
	logic       lockout;
	logic       cfg_wr;
	logic       rom_wr;

	assign data_u = cpu_data;
	assign cfg_wr = !cpu_rw && romsel && (cpu_addr[14:12] == 3'b101) && !lockout; // $5000-$5FFF
	assign rom_wr = !cpu_rw && !romsel; // $8000-$FFFF

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			mapper          <= '0;
			prg_base        <= '0;
			prg_mask        <= '0;
			chr_mask        <= '0;
			sram_page       <= '0;
			sram_en         <= 1'b0;
			prg_we_en       <= 1'b0;
			chr_we_en       <= 1'b0;
			mirroring       <= MIRROR_VERT;
			lockout         <= 1'b0;
			bank_sel        <= '0;
			mmc3_prg_mode   <= 1'b0;
			mmc3_chr_invert <= 1'b0;
			irq_latch       <= '0;
			reload_req      <= 1'b0;
			irq_enable_set  <= 1'b0;
			irq_disable     <= 1'b0;
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else
		begin
			reload_req     <= 1'b0;     // Pulses last one cycle
			irq_enable_set <= 1'b0;
			irq_disable    <= 1'b0;
			if (cfg_wr)
			begin
				case (cpu_addr[2:0])
					3'd0: prg_base[12:8] <= cpu_data[4:0];     // A26..A22
					3'd1: prg_base[7:0]  <= cpu_data;          // A21..A14
					3'd2: prg_mask       <= cpu_data[4:0];
					3'd3: regs[0]        <= cpu_data;          // NROM CHR bank
					3'd4: chr_mask       <= cpu_data[4:0];
					3'd5: {regs[1][5:0], sram_page} <= cpu_data;
					3'd6: mapper         <= cpu_data[4:0];
					3'd7:
					begin
						lockout   <= data_u.ctrl_view.lockout;
						mirroring <= data_u.ctrl_view.mirroring;
						prg_we_en <= data_u.ctrl_view.prg_we_en;
						chr_we_en <= data_u.ctrl_view.chr_we_en;
						sram_en   <= data_u.ctrl_view.sram_en;
					end
					default: ;
				endcase
			end
			if (rom_wr)
			begin
				case (mapper)
					MAPPER_UXROM: regs[1] <= cpu_data; // PRG bank
					MAPPER_CNROM: regs[0] <= cpu_data; // CHR bank
					MAPPER_AXROM:
					begin
						regs[1][4:0] <= cpu_data[4:0];
						mirroring    <= {1'b1, cpu_data[4]}; // One-screen page from bit 4
					end
					MAPPER_MMC3:
					begin
						case ({cpu_addr[14:13], cpu_addr[0]})
							3'b000:                            // $8000 bank select
							begin
								bank_sel        <= data_u.sel_view.reg_idx;
								mmc3_prg_mode   <= data_u.sel_view.prg_mode;
								mmc3_chr_invert <= data_u.sel_view.chr_invert;
							end
							3'b001: regs[bank_sel] <= cpu_data; // $8001 bank data
							3'b010: mirroring <= cpu_data[0] ? MIRROR_HORIZ : MIRROR_VERT;
							3'b100: irq_latch      <= cpu_data; // $C000
							3'b101: reload_req     <= 1'b1;     // $C001
							3'b110: irq_disable    <= 1'b1;     // $E000, also acks
							3'b111: irq_enable_set <= 1'b1;     // $E001
							default: ;                          // $A001 RAM protect ignored
						endcase
					end
					default: ;                                  // NROM, no bank writes
				endcase
			end
		end
	end

	assign bank_r0 = regs[0];
	assign bank_r1 = regs[1];
	assign bank_r2 = regs[2];
	assign bank_r3 = regs[3];
	assign bank_r4 = regs[4];
	assign bank_r5 = regs[5];
	assign bank_r6 = regs[6];
	assign bank_r7 = regs[7];

endmodule

// ==== logic/mapper_pkg.sv ====
package mapper_pkg;

	typedef logic [4:0] mapper_t;                 // Mapper number from $5xx6
	localparam mapper_t MAPPER_UXROM = 5'd1;      // 16K switch + fixed last
	localparam mapper_t MAPPER_CNROM = 5'd2;      // 8K CHR switch
	localparam mapper_t MAPPER_AXROM = 5'd8;      // 32K switch, one-screen
	localparam mapper_t MAPPER_MMC3  = 5'd20;     // Banks plus scanline IRQ

	typedef logic [7:0] bank_reg_t;               // One bank register word

	typedef logic [1:0] mirror_t;                 // Nametable mode
	localparam mirror_t MIRROR_VERT   = 2'd0;     // CIRAM A10 from PPU A10
	localparam mirror_t MIRROR_HORIZ  = 2'd1;     // CIRAM A10 from PPU A11
	localparam mirror_t MIRROR_ONE_A  = 2'd2;     // Lower page only
	localparam mirror_t MIRROR_ONE_B  = 2'd3;     // Upper page only

	localparam int PRG_OUT_W = 14;                // PRG A26..A13
	localparam int CHR_OUT_W = 8;                 // CHR A17..A10

	// A CPU data byte seen as the $5xx7 control byte or as the MMC3 bank select
	typedef union packed
	{
		struct packed
		{
			logic       lockout;                  // Freezes $5xxx writes
			logic [1:0] spare;
			mirror_t    mirroring;
			logic       prg_we_en;                // Flash writes allowed
			logic       chr_we_en;                // CHR RAM writes allowed
			logic       sram_en;
		} ctrl_view;
		struct packed
		{
			logic       chr_invert;               // Swap 2K and 1K halves
			logic       prg_mode;                 // Swap $8000 and $C000 slots
			logic [2:0] spare;
			logic [2:0] reg_idx;                  // Target of next odd write
		} sel_view;
	} cpu_byte_u;

endpackage

// ==== logic/scanline_irq_counter.sv ====
`timescale 1ns/1ps
module scanline_irq_counter
	import mapper_pkg::*;
(
	input  logic       m2,
	input  logic       ppu_addr_in,     // Async reset
	input  logic       a12_tick,        // Qualified A12 rise
	input  logic [7:0] irq_latch,
	input  logic       reload_req,      // $C001 pulse
	input  logic       irq_enable_set,  // $E001 pulse
	input  logic       irq_disable,     // $E000 pulse
	output logic       irq              // Active high level
);
	logic [7:0] count;                  // Scanlines left
	logic [7:0] next_count;
	logic       reload_flag;
	logic       irq_enabled;
	logic       do_reload;

	assign do_reload = reload_flag || (count == 8'd0);

	always_comb
	begin
		next_count = do_reload ? irq_latch : count - 8'd1; // Reload or count down
	end

	always_ff @(posedge m2 or posedge ppu_addr_in)
	begin
		if (ppu_addr_in)
		begin
			count       <= '0;
			reload_flag <= 1'b0;
			irq_enabled <= 1'b0;
			irq         <= 1'b0;
		end
		else
		begin
			if (a12_tick)
			begin
				count <= next_count;
				if (do_reload)
					reload_flag <= 1'b0;
				if ((next_count == 8'd0) && irq_enabled && !irq_disable)
					irq <= 1'b1;            // Held until acked
			end
			if (reload_req)
				reload_flag <= 1'b1;        // Later request wins over the clear
			if (irq_disable)
			begin
				irq_enabled <= 1'b0;
				irq         <= 1'b0;        // Ack drops the line
			end
			else if (irq_enable_set)
				irq_enabled <= 1'b1;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --top-module tb_cart_mapper -f build.f \
	&& ./obj_dir/Vtb_cart_mapper > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -q "^TEST PASSED$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== test/mapper_monitor.sv ====
`timescale 1ns/1ps
module mapper_monitor
(
	input  logic        m2,
	input  logic        ppu_addr_in,      // No checks during reset
	input  logic        probe_en,         // Expected values valid this cycle
	input  logic [13:0] exp_prg,
	input  logic [7:0]  exp_chr,
	input  logic [2:0]  exp_flags,        // {sram_ce, ciram_a10, irq}
	input  logic [4:0]  check_mask,       // {prg, chr, sram_ce, ciram_a10, irq}
	input  logic [5:0]  exp_strobes,      // {flash_we, flash_oe, sram_we, sram_oe, chr_oe, chr_we}
	input  logic [13:0] prg_addr,
	input  logic [7:0]  chr_addr,
	input  logic        sram_ce,
	input  logic        ciram_a10,
	input  logic        irq,
	input  logic        flash_we,
	input  logic        flash_oe,
	input  logic        sram_we,
	input  logic        sram_oe,
	input  logic        chr_oe,
	input  logic        chr_we,
	output int          error_count,
	output int          check_count
);

	initial
	begin
		error_count = 0;
		check_count = 0;
	end

	task automatic compare_value(input string name, input logic [13:0] actual,
		input logic [13:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("CHECK FAILED %s expected 0x%0h got 0x%0h at %0t",
				name, expected, actual, $time);
		end
	endtask

	// Values seen here are the ones held through the probe cycle
	always @(posedge m2)
	begin
		if (!ppu_addr_in && probe_en)
		begin
			if (check_mask[4])
				compare_value("prg_addr", prg_addr, exp_prg);
			if (check_mask[3])
				compare_value("chr_addr", {6'b0, chr_addr}, {6'b0, exp_chr});
			if (check_mask[2])
				compare_value("sram_ce", {13'b0, sram_ce}, {13'b0, exp_flags[2]});
			if (check_mask[1])
				compare_value("ciram_a10", {13'b0, ciram_a10}, {13'b0, exp_flags[1]});
			if (check_mask[0])
				compare_value("irq", {13'b0, irq}, {13'b0, exp_flags[0]});
			compare_value("flash_we", {13'b0, flash_we}, {13'b0, exp_strobes[5]});
			compare_value("flash_oe", {13'b0, flash_oe}, {13'b0, exp_strobes[4]});
			compare_value("sram_we", {13'b0, sram_we}, {13'b0, exp_strobes[3]});
			compare_value("sram_oe", {13'b0, sram_oe}, {13'b0, exp_strobes[2]});
			compare_value("chr_oe", {13'b0, chr_oe}, {13'b0, exp_strobes[1]});
			compare_value("chr_we", {13'b0, chr_we}, {13'b0, exp_strobes[0]});
		end
	end

endmodule

// ==== test/mapper_stim.mem ====
// op_romsel_cpuaddr_data_ppuaddr_expprg_expchr_flags_mask, op 1 write, 2 A12 lows+rise, 3 probe, 0 end
// flags {sram_ce,ciram_a10,irq}, mask {prg,chr,sram_ce,ciram_a10,irq}, data of op 2 is the low count
// Outer config, SRAM page 2 with SRAM off, then UxROM bank 5
1_1_5000_01_0000_0000_00_0_00
1_1_5001_38_0000_0000_00_0_00
1_1_5002_18_0000_0000_00_0_00
1_1_5004_1C_0000_0000_00_0_00
1_1_5005_16_0000_0000_00_0_00
1_1_5006_01_0000_0000_00_0_00
3_1_6000_00_0000_0002_00_4_14
1_0_0000_05_0000_0000_00_0_00
3_0_0000_00_0000_027A_00_0_10
3_0_2000_00_0000_027B_00_0_10
3_0_4000_00_0000_027E_00_0_10
3_0_6000_00_0000_027F_00_0_10
// AxROM 32K bank 3, one-screen page from bit 4
1_1_5006_08_0000_0000_00_0_00
1_0_0000_13_0000_0000_00_0_00
3_0_0000_00_2400_027C_00_2_12
3_0_6000_00_2800_027F_00_2_12
1_0_0000_03_0000_0000_00_0_00
3_0_0000_00_2400_027C_00_0_12
// CNROM CHR bank 0x0E under CHR mask 0x1C
1_1_5006_02_0000_0000_00_0_00
1_0_0000_0E_0000_0000_00_0_00
3_0_0000_00_0400_0000_11_0_08
3_0_0000_00_1C00_0000_17_0_08
// MMC3 bank registers r0..r7
1_1_5004_00_0000_0000_00_0_00
1_1_5006_14_0000_0000_00_0_00
1_0_0000_00_0000_0000_00_0_00
1_0_0001_20_0000_0000_00_0_00
1_0_0000_01_0000_0000_00_0_00
1_0_0001_26_0000_0000_00_0_00
1_0_0000_02_0000_0000_00_0_00
1_0_0001_04_0000_0000_00_0_00
1_0_0000_03_0000_0000_00_0_00
1_0_0001_05_0000_0000_00_0_00
1_0_0000_04_0000_0000_00_0_00
1_0_0001_06_0000_0000_00_0_00
1_0_0000_05_0000_0000_00_0_00
1_0_0001_07_0000_0000_00_0_00
1_0_0000_06_0000_0000_00_0_00
1_0_0001_09_0000_0000_00_0_00
1_0_0000_07_0000_0000_00_0_00
1_0_0001_0C_0000_0000_00_0_00
3_0_0000_00_0400_0279_21_0_18
3_0_2000_00_0800_027C_26_0_18
3_0_4000_00_1000_027E_04_0_18
3_0_6000_00_1C00_027F_07_0_18
// PRG mode 1 and CHR inversion
1_0_0000_C0_0000_0000_00_0_00
3_0_0000_00_0400_027E_05_0_18
3_0_2000_00_0800_027C_06_0_18
3_0_4000_00_1400_0279_21_0_18
3_0_6000_00_1C00_027F_27_0_18
// Scanline IRQ, latch 2, rises with glitches between
3_0_0000_00_1000_0000_00_0_01
1_0_4000_02_0000_0000_00_0_00
1_0_4001_00_0000_0000_00_0_00
1_0_6001_00_0000_0000_00_0_00
2_0_0000_03_0000_0000_00_0_00
3_0_0000_00_1000_0000_00_0_01
2_0_0000_01_0000_0000_00_0_00
2_0_0000_03_0000_0000_00_0_00
2_0_0000_01_0000_0000_00_0_00
2_0_0000_03_0000_0000_00_0_00
3_0_0000_00_1000_0000_00_0_01
3_0_0000_00_1000_0000_00_1_01
3_0_0000_00_1000_0000_00_1_01
1_0_6000_00_0000_0000_00_0_00
3_0_0000_00_1000_0000_00_1_01
3_0_0000_00_1000_0000_00_0_01
// Lockout with SRAM on, later config writes ignored
1_1_5007_81_0000_0000_00_0_00
1_1_5001_00_0000_0000_00_0_00
1_1_5006_01_0000_0000_00_0_00
3_0_0000_00_1000_027E_00_0_10
3_1_6000_00_1000_0002_00_0_14
3_1_5000_00_1000_0000_00_4_04
0_0_0000_00_0000_0000_00_0_00

// ==== test/tb_cart_mapper.sv ====
`timescale 1ns/1ps
module tb_cart_mapper;

	localparam int MAX_OPS       = 128;
	localparam int RESET_CYCLES  = 10;
	localparam int CYCLES_PER_OP = 20;                // Longest op takes 4 cycles

	logic        m2;
	logic        ppu_addr_in;                         // Async reset
	logic        romsel;
	logic        cpu_rw;
	logic [14:0] cpu_addr;
	logic [7:0]  cpu_data;
	logic        ppu_rd;
	logic        ppu_wr;
	logic [13:0] ppu_addr;
	logic [13:0] prg_addr;
	logic [7:0]  chr_addr;
	logic        flash_we;
	logic        flash_oe;
	logic        sram_ce;
	logic        sram_we;
	logic        sram_oe;
	logic        chr_oe;
	logic        chr_we;
	logic        ciram_a10;
	logic        irq;

	logic        probe_en;                            // Expected values valid
	logic [13:0] exp_prg;
	logic [7:0]  exp_chr;
	logic [2:0]  exp_flags;                           // {sram_ce, ciram_a10, irq}
	logic [4:0]  check_mask;                          // {prg, chr, sram_ce, ciram_a10, irq}
	logic [5:0]  exp_strobes;                         // {flash_we, flash_oe, sram_we, sram_oe, chr_oe, chr_we}
	int          error_count;
	int          check_count;

	logic [83:0] ops [0:MAX_OPS-1];                   // One packed operation per entry
	int          op_count;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	cart_mapper_top #(.A12_LOW_CYCLES(3)) cart_mapper_top_inst (
		.m2, .ppu_addr_in, .romsel, .cpu_rw, .cpu_addr, .cpu_data,
		.ppu_rd, .ppu_wr, .ppu_addr,
		.prg_addr, .chr_addr, .flash_we, .flash_oe,
		.sram_ce, .sram_we, .sram_oe, .chr_oe, .chr_we, .ciram_a10, .irq
	);

	mapper_monitor mapper_monitor_inst (
		.m2, .ppu_addr_in, .probe_en, .exp_prg, .exp_chr, .exp_flags, .check_mask,
		.exp_strobes,
		.prg_addr, .chr_addr, .sram_ce, .ciram_a10, .irq,
		.flash_we, .flash_oe, .sram_we, .sram_oe, .chr_oe, .chr_we,
		.error_count, .check_count
	);

	always #5 m2 = ~m2;                               // 10 ns period

	always @(posedge m2)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
		begin
			$display("Timeout, run went past %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic int count_ops();
		int n;
		n = 0;
		while (n < MAX_OPS && ops[n][83:80] inside {4'h1, 4'h2, 4'h3})
			n++;
		return n;
	endfunction

	task automatic write_cpu(input logic rs, input logic [14:0] addr, input logic [7:0] data);
		@(posedge m2);
		#1;
		probe_en = 1'b0;
		romsel   = rs;
		cpu_addr = addr;
		cpu_data = data;
		cpu_rw   = 1'b0;                              // Captured at the next edge
	endtask

	task automatic pulse_a12(input int lows);
		for (int i = 0; i < lows; i++)
		begin
			@(posedge m2);
			#1;
			probe_en = 1'b0;
			cpu_rw   = 1'b1;
			ppu_addr = 14'h0000;                      // A12 low
		end
		@(posedge m2);
		#1;
		ppu_addr = 14'h1000;                          // Rise and stay high
	endtask

	task automatic probe_outputs(input logic [83:0] op);
		@(posedge m2);
		#1;
		romsel      = op[76];
		cpu_addr    = op[74:60];
		cpu_rw      = 1'b1;
		ppu_addr    = op[49:36];
		ppu_rd      = 1'b0;                           // PPU fetch at the probed address
		exp_prg     = op[33:20];
		exp_chr     = op[19:12];
		exp_flags   = op[10:8];
		check_mask  = op[4:0];
		exp_strobes = {1'b1, op[76], 1'b1, 1'b0, op[49], 1'b1}; // Read strobes only
		probe_en    = 1'b1;                           // Monitor compares at next edge
	endtask

	task automatic run_op(input logic [83:0] op);
		logic [3:0] kind;
		kind = op[83:80];
		case (kind)
			4'h1: write_cpu(op[76], op[74:60], op[59:52]);
			4'h2: pulse_a12(int'(op[59:52]));
			default: probe_outputs(op);
		endcase
	endtask

	initial
	begin
		m2          = 1'b0;
		ppu_addr_in = 1'b1;
		romsel      = 1'b1;
		cpu_rw      = 1'b1;
		cpu_addr    = '0;
		cpu_data    = '0;
		ppu_rd      = 1'b1;
		ppu_wr      = 1'b1;
		ppu_addr    = '0;
		probe_en    = 1'b0;
		exp_prg     = '0;
		exp_chr     = '0;
		exp_flags   = '0;
		check_mask  = '0;
		exp_strobes = '0;
		for (int i = 0; i < MAX_OPS; i++)
			ops[i] = '0;                              // Unloaded entries end the list
		$readmemh("test/mapper_stim.mem", ops);
		op_count    = count_ops();
		cycle_limit = op_count * CYCLES_PER_OP + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge m2);
		#1;
		ppu_addr_in = 1'b0;
		for (int i = 0; i < op_count; i++)
			run_op(ops[i]);
		@(posedge m2);                                // Last probe compared here
		#1;
		probe_en = 1'b0;
		$display("Checks run %0d, errors %0d", check_count, error_count);
		if (check_count == 0)
			$display("No checks ran, the stimulus file is missing or empty");
		if (error_count == 0 && check_count > 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
